// File: common/mips_pkg.sv
package mips_pkg;

    // byte address width on the Avalon bus
    localparam int addr_width = 32;

    // RAM depth in 32-bit words, indexed by byte address bits above the word offset
    localparam int mem_words = 256;
    localparam int mem_index_bits = $clog2(mem_words);

    // first instruction fetched after start
    localparam logic [addr_width-1:0] reset_vector = 32'h0000_0004;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special instructions, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    // fetch and memory each take two cycles, execute takes one
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_execute,
        st_memory
    } cpu_state_e;

endpackage

// File: cpu/cpu_alu.sv
`timescale 1ns/100ps

module cpu_alu (
    input  mips_pkg::alu_op_e alu_op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    logic [4:0] shamt;

    // the decoder places the shift amount in the low bits of b
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'd0, a < b};
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_lui:  result = {b[15:0], 16'h0000};
            default:  result = 32'd0;
        endcase
    end

    // beq and bne look at this after a subtraction
    assign zero = (result == 32'd0);

endmodule

// File: cpu/cpu_decoder.sv
`timescale 1ns/100ps

module cpu_decoder (
    input  logic [31:0]       instr,
    output logic [4:0]        rs_addr,
    output logic [4:0]        rt_addr,
    output logic [4:0]        rd_sel,
    output logic [31:0]       imm,
    output logic              use_imm,
    output mips_pkg::alu_op_e alu_op,
    output logic              reg_write,
    output logic              is_load,
    output logic              is_store,
    output logic              is_branch,
    output logic              branch_ne,
    output logic              is_jr
);
    import mips_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct = funct_e'(instr[5:0]);
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};
    assign rt_addr = instr[20:16];

    always_comb begin
        rs_addr = instr[25:21];
        rd_sel = instr[20:16];
        imm = imm_sext;
        use_imm = 1'b0;
        alu_op = alu_add;
        reg_write = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jr = 1'b0;
        case (opcode)
            op_special: begin
                rd_sel = instr[15:11];
                reg_write = 1'b1;
                case (funct)
                    fn_sll, fn_srl: begin
                        // shifts operate on rt, so it is read through the rs port
                        rs_addr = instr[20:16];
                        imm = {27'd0, instr[10:6]};
                        use_imm = 1'b1;
                        alu_op = (funct == fn_sll) ? alu_sll : alu_srl;
                    end
                    fn_jr: begin
                        reg_write = 1'b0;
                        is_jr = 1'b1;
                    end
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu, op_sltiu: begin
                use_imm = 1'b1;
                reg_write = 1'b1;
                alu_op = (opcode == op_sltiu) ? alu_sltu : alu_add;
            end
            // the logical immediates zero-extend
            op_andi, op_ori, op_xori: begin
                imm = imm_zext;
                use_imm = 1'b1;
                reg_write = 1'b1;
                case (opcode)
                    op_andi: alu_op = alu_and;
                    op_ori:  alu_op = alu_or;
                    default: alu_op = alu_xor;
                endcase
            end
            op_lui: begin
                imm = imm_zext;
                use_imm = 1'b1;
                reg_write = 1'b1;
                alu_op = alu_lui;
            end
            op_lw, op_sw: begin
                use_imm = 1'b1;
                reg_write = (opcode == op_lw);
                is_load = (opcode == op_lw);
                is_store = (opcode == op_sw);
            end
            op_beq, op_bne: begin
                is_branch = 1'b1;
                branch_ne = (opcode == op_bne);
                alu_op = alu_sub;
            end
            default: begin
                // anything outside the subset retires as a nop
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

// File: cpu/cpu_regfile.sv
`timescale 1ns/100ps

module cpu_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero reads as zero whatever the array holds
    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

    assign register_v0 = regs[2];

endmodule

// File: cpu/cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    output logic                            active,
    // Avalon master
    output logic [mips_pkg::addr_width-1:0] address,
    output logic                            read,
    output logic                            write,
    output logic [31:0]                     writedata,
    input  logic [31:0]                     readdata,
    input  logic                            waitrequest,
    // decoder
    output logic [31:0]                     instr,
    input  logic [4:0]                      rd_sel,
    input  logic [31:0]                     imm,
    input  logic                            use_imm,
    input  logic                            reg_write,
    input  logic                            is_load,
    input  logic                            is_store,
    input  logic                            is_branch,
    input  logic                            branch_ne,
    input  logic                            is_jr,
    // register file
    input  logic [31:0]                     rs_data,
    input  logic [31:0]                     rt_data,
    output logic                            wr_en,
    output logic [4:0]                      wr_addr,
    output logic [31:0]                     wr_data,
    // ALU
    output logic [31:0]                     alu_a,
    output logic [31:0]                     alu_b,
    input  logic [31:0]                     alu_result,
    input  logic                            alu_zero
);
    import mips_pkg::*;

    cpu_state_e            state;
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] pc_plus4;
    logic [addr_width-1:0] branch_target;
    logic                  branch_taken;
    logic                  halt;

    assign pc_plus4 = pc + 32'd4;

    // branch offset counts words relative to the following instruction
    assign branch_target = pc_plus4 + {imm[29:0], 2'b00};

    // beq and bne both subtract, so only the sense of the zero flag differs
    assign branch_taken = is_branch && (alu_zero != branch_ne);

    // jr to address 0 ends the program
    assign halt = is_jr && (rs_data == 32'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            pc <= reset_vector;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        pc <= reset_vector;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (!waitrequest) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (is_jr) begin
                        pc <= rs_data;
                    end else if (branch_taken) begin
                        pc <= branch_target;
                    end else begin
                        pc <= pc_plus4;
                    end
                    if (is_load || is_store) begin
                        state <= st_memory;
                    end else if (halt) begin
                        state <= st_idle;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_memory: begin
                    if (!waitrequest) begin
                        state <= st_fetch;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // instruction register captures the word on the completing fetch edge
    always_ff @(posedge clk) begin
        if (state == st_fetch && !waitrequest) begin
            instr <= readdata;
        end
    end

    assign active = (state != st_idle);

    // the ALU result stays stable through memory since neither instr nor the registers change
    assign read = (state == st_fetch) || (state == st_memory && is_load);
    assign write = (state == st_memory) && is_store;
    assign address = (state == st_fetch) ? pc : alu_result;
    assign writedata = rt_data;

    assign alu_a = rs_data;
    assign alu_b = use_imm ? imm : rt_data;

    // ALU results retire in execute, loaded words when the read completes
    assign wr_en = ((state == st_execute) && reg_write && !is_load) ||
                   ((state == st_memory) && is_load && !waitrequest);
    assign wr_addr = rd_sel;
    assign wr_data = is_load ? readdata : alu_result;

endmodule

// File: hdl/avalon_ram.sv
`timescale 1ns/100ps

module avalon_ram (
    input  logic                            clk,
    input  logic                            rst,
    // Avalon slave
    input  logic [mips_pkg::addr_width-1:0] address,
    input  logic                            read,
    input  logic                            write,
    input  logic [31:0]                     writedata,
    output logic [31:0]                     readdata,
    output logic                            waitrequest,
    // program load port
    input  logic                            load_valid,
    input  logic [mips_pkg::addr_width-1:0] load_addr,
    input  logic [31:0]                     load_data,
    output logic                            load_ready
);
    import mips_pkg::*;

    logic [31:0]               mem [mem_words];
    logic                      phase;
    logic                      bus_busy;
    logic [mem_index_bits-1:0] bus_index;
    logic [mem_index_bits-1:0] load_index;

    assign bus_busy = read || write;

    // word index from the byte address, higher bits ignored
    assign bus_index = address[mem_index_bits+1:2];
    assign load_index = load_addr[mem_index_bits+1:2];

    // phase is low in the first cycle of an access and high in the second
    assign waitrequest = bus_busy && !phase;
    assign load_ready = !bus_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= 1'b0;
        end else begin
            phase <= bus_busy && !phase;
        end
    end

    // the read is registered in the wait cycle so readdata is ready in the second
    always_ff @(posedge clk) begin
        if (read && !phase) begin
            readdata <= mem[bus_index];
        end
        if (write && phase) begin
            mem[bus_index] <= writedata;
        end
        if (load_valid && load_ready) begin
            mem[load_index] <= load_data;
        end
    end

endmodule

// File: hdl/mips_system.sv
`timescale 1ns/100ps

module mips_system (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        active,
    output logic [31:0] register_v0,
    input  logic        load_valid,
    output logic        load_ready,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);
    import mips_pkg::*;

    // Avalon bus between the CPU and the RAM
    logic [addr_width-1:0] address;
    logic                  read;
    logic                  write;
    logic [31:0]           writedata;
    logic [31:0]           readdata;
    logic                  waitrequest;

    // decoded instruction
    logic [31:0] instr;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [4:0]  rd_sel;
    logic [31:0] imm;
    logic        use_imm;
    alu_op_e     alu_op;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jr;

    // register file and ALU
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;

    cpu_control u_cpu_control (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .instr       (instr),
        .rd_sel      (rd_sel),
        .imm         (imm),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_branch   (is_branch),
        .branch_ne   (branch_ne),
        .is_jr       (is_jr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .alu_zero    (alu_zero)
    );

    cpu_decoder u_cpu_decoder (
        .instr     (instr),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rd_sel    (rd_sel),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .reg_write (reg_write),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_branch (is_branch),
        .branch_ne (branch_ne),
        .is_jr     (is_jr)
    );

    cpu_regfile u_cpu_regfile (
        .clk         (clk),
        .rst         (rst),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    cpu_alu u_cpu_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    avalon_ram u_avalon_ram (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_ready  (load_ready)
    );

endmodule

// File: testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// R-type word: fields are rd, rs, rt and the shift amount
function automatic logic [31:0] r_type(input funct_e fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
endfunction

// I-type word: rt is the destination or the second compare register
function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jr_zero();
    return r_type(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0);
endfunction

function automatic void emit(input logic [31:0] word);
    program_words.push_back(word);
endfunction

// xor of two small constants into v0
task automatic xor_program();
    program_words.delete();
    emit(i_type(op_addiu, 5'd3, 5'd0, 16'h00FF));
    emit(i_type(op_addiu, 5'd4, 5'd0, 16'h0F0F));
    emit(r_type(fn_xor, 5'd2, 5'd3, 5'd4, 5'd0));
    emit(jr_zero());
endtask

task automatic alu_program(input logic [15:0] a, input logic [15:0] b);
    logic [31:0] ops [15];
    ops[0] = r_type(fn_addu, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[1] = r_type(fn_subu, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[2] = r_type(fn_and, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[3] = r_type(fn_or, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[4] = r_type(fn_xor, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[5] = r_type(fn_slt, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[6] = r_type(fn_sltu, 5'd5, 5'd3, 5'd4, 5'd0);
    ops[7] = r_type(fn_sll, 5'd5, 5'd0, 5'd4, a[4:0]);
    ops[8] = r_type(fn_srl, 5'd5, 5'd0, 5'd3, b[4:0]);
    ops[9] = i_type(op_addiu, 5'd5, 5'd3, b);
    ops[10] = i_type(op_andi, 5'd5, 5'd3, b);
    ops[11] = i_type(op_ori, 5'd5, 5'd3, b);
    ops[12] = i_type(op_xori, 5'd5, 5'd3, b);
    ops[13] = i_type(op_sltiu, 5'd5, 5'd3, b);
    ops[14] = i_type(op_lui, 5'd5, 5'd0, a);
    program_words.delete();
    emit(i_type(op_addiu, 5'd3, 5'd0, a));
    emit(i_type(op_addiu, 5'd4, 5'd0, b));
    emit(r_type(fn_addu, 5'd2, 5'd0, 5'd0, 5'd0));
    // v0 becomes result minus v0 after each operation, so the order of results matters
    foreach (ops[i]) begin
        emit(ops[i]);
        emit(r_type(fn_subu, 5'd2, 5'd5, 5'd2, 5'd0));
    end
    emit(jr_zero());
endtask

// counts $3 down to zero and adds every count except the one equal to $4
task automatic loop_program(input logic [15:0] count, input logic [15:0] skip);
    program_words.delete();
    emit(i_type(op_addiu, 5'd3, 5'd0, count));
    emit(r_type(fn_addu, 5'd2, 5'd0, 5'd0, 5'd0));
    emit(i_type(op_addiu, 5'd4, 5'd0, skip));
    emit(i_type(op_beq, 5'd4, 5'd3, 16'h0001));
    emit(r_type(fn_addu, 5'd2, 5'd2, 5'd3, 5'd0));
    emit(i_type(op_addiu, 5'd3, 5'd3, 16'hFFFF));
    emit(i_type(op_bne, 5'd0, 5'd3, 16'hFFFC));
    emit(jr_zero());
endtask

task automatic store_load_program(input logic [31:0] word);
    program_words.delete();
    emit(i_type(op_lui, 5'd3, 5'd0, word[31:16]));
    emit(i_type(op_ori, 5'd3, 5'd3, word[15:0]));
    emit(i_type(op_sw, 5'd3, 5'd0, 16'h0200));
    emit(i_type(op_lw, 5'd6, 5'd0, 16'h0200));
    emit(r_type(fn_addu, 5'd2, 5'd6, 5'd0, 5'd0));
    emit(jr_zero());
endtask

task automatic preload_read_program(input logic [15:0] offset);
    program_words.delete();
    emit(i_type(op_lw, 5'd2, 5'd0, offset));
    emit(jr_zero());
endtask

task automatic straight_program(input int count);
    logic [31:0] r;
    program_words.delete();
    for (int i = 0; i < count; i++) begin
        r = next_random();
        emit(i_type(i[0] ? op_xori : op_addiu, 5'd2, 5'd2, r[15:0]));
    end
    emit(jr_zero());
endtask

`endif

// File: testbench/mips_system_tb.sv
`timescale 1ns/100ps

module mips_system_tb;
    import mips_pkg::*;

    // per-program bound of load cycles plus run cycles, for the longest random case
    localparam int alu_run_cycles = 34 + 3 * 34;
    localparam int worst_case_cycles = 4 + 20 * alu_run_cycles + (4 + 3 * 4) + (9 + 240)
                                       + (6 + 22) + (2 + 8) + (20 + 3 * 20) + 25 * 4;
    localparam int watchdog_cycles = 2 * worst_case_cycles;
    localparam logic [31:0] preload_addr = 32'h0000_0300;

    logic        clk;
    logic        rst;
    logic        start;
    logic        active;
    logic [31:0] register_v0;
    logic        load_valid;
    logic        load_ready;
    logic [31:0] load_addr;
    logic [31:0] load_data;

    logic [31:0] program_words [$];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    logic [31:0] rng_state;

    mips_system u_mips_system (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .active      (active),
        .register_v0 (register_v0),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("[ERROR] time %0d ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    `include "tb_programs.svh"

    // instruction-level model: 3 cycles per instruction, 2 more for lw and sw
    task automatic model_run(output logic [31:0] v0, output int cycles);
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0]  dst;
        logic        wb;
        logic        done;
        pc = reset_vector;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            if (cycles > 100000) begin
                stop_on_error("reference model never reached jr to address 0");
            end
            ins = model_mem[pc[9:2]];
            rs_v = model_regs[ins[25:21]];
            rt_v = model_regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = rs_v + simm;
            pc = pc + 32'd4;
            cycles += 3;
            dst = ins[20:16];
            wb = 1'b1;
            val = 32'd0;
            case (opcode_e'(ins[31:26]))
                op_special: begin
                    dst = ins[15:11];
                    case (funct_e'(ins[5:0]))
                        fn_sll:  val = rt_v << ins[10:6];
                        fn_srl:  val = rt_v >> ins[10:6];
                        fn_addu: val = rs_v + rt_v;
                        fn_subu: val = rs_v - rt_v;
                        fn_and:  val = rs_v & rt_v;
                        fn_or:   val = rs_v | rt_v;
                        fn_xor:  val = rs_v ^ rt_v;
                        fn_slt:  val = {31'd0, $signed(rs_v) < $signed(rt_v)};
                        fn_sltu: val = {31'd0, rs_v < rt_v};
                        fn_jr: begin
                            wb = 1'b0;
                            pc = rs_v;
                            done = (rs_v == 32'd0);
                        end
                        default: wb = 1'b0;
                    endcase
                end
                op_addiu: val = rs_v + simm;
                op_sltiu: val = {31'd0, rs_v < simm};
                op_andi:  val = rs_v & {16'h0000, ins[15:0]};
                op_ori:   val = rs_v | {16'h0000, ins[15:0]};
                op_xori:  val = rs_v ^ {16'h0000, ins[15:0]};
                op_lui:   val = {ins[15:0], 16'h0000};
                op_lw: begin
                    val = model_mem[addr[9:2]];
                    cycles += 2;
                end
                op_sw: begin
                    model_mem[addr[9:2]] = rt_v;
                    wb = 1'b0;
                    cycles += 2;
                end
                op_beq, op_bne: begin
                    wb = 1'b0;
                    if ((rs_v == rt_v) == (ins[31:26] == op_beq)) begin
                        pc = pc + {simm[29:0], 2'b00};
                    end
                end
                default: wb = 1'b0;
            endcase
            if (wb && dst != 5'd0) begin
                model_regs[dst] = val;
            end
        end
        v0 = model_regs[2];
    endtask

    // offers one word and returns after the negedge before the accepting edge
    task automatic load_word(input logic [31:0] addr, input logic [31:0] data,
                             output int waited);
        waited = 0;
        @(posedge clk);
        load_valid <= 1'b1;
        load_addr <= addr;
        load_data <= data;
        @(negedge clk);
        while (!load_ready) begin
            waited++;
            @(negedge clk);
        end
        model_mem[addr[9:2]] = data;
    endtask

    task automatic end_load();
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic load_program();
        logic [31:0] addr;
        int          waited;
        addr = reset_vector;
        foreach (program_words[i]) begin
            load_word(addr, program_words[i], waited);
            assert (waited == 0)
                else stop_on_error("load port stalled while the CPU was idle");
            addr = addr + 32'd4;
        end
        end_load();
    endtask

    task automatic run_program(output int cycles);
        cycles = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (active) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic execute_and_check(input string name, output logic [31:0] v0_seen,
                                     output int cycles_seen);
        logic [31:0] v0_exp;
        int          cycles_exp;
        load_program();
        model_run(v0_exp, cycles_exp);
        run_program(cycles_seen);
        v0_seen = register_v0;
        assert (v0_seen === v0_exp)
            else stop_on_error($sformatf("%s: v0 is %h, model gives %h", name, v0_seen, v0_exp));
        assert (cycles_seen == cycles_exp)
            else stop_on_error($sformatf("%s: active for %0d cycles, model gives %0d",
                                         name, cycles_seen, cycles_exp));
    endtask

    // waits for the first fetch, then offers a word that must stall until the bus is idle
    task automatic offer_during_fetch(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        @(negedge clk);
        while (!u_mips_system.read) begin
            @(negedge clk);
        end
        load_word(addr, data, waited);
        assert (waited > 0)
            else stop_on_error("load port accepted a word while the CPU fetched");
        end_load();
    endtask

    assert property (@(posedge clk) disable iff (rst)
        !(u_mips_system.read && u_mips_system.write))
        else stop_on_error("read and write high together");

    assert property (@(posedge clk) disable iff (rst)
        (u_mips_system.read || u_mips_system.write) && u_mips_system.waitrequest |=>
        $stable(u_mips_system.address) && $stable(u_mips_system.writedata) &&
        $stable(u_mips_system.read) && $stable(u_mips_system.write))
        else stop_on_error("bus request changed while waitrequest was high");

    assert property (@(posedge clk) disable iff (rst) $rose(active) |-> $past(start))
        else stop_on_error("active rose without a start pulse");

    assert property (@(posedge clk) disable iff (rst) !active |-> load_ready)
        else stop_on_error("load_ready low while the CPU was idle");

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired before the programs finished");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        logic [31:0] preload;
        logic [31:0] v0_seen;
        int          cycles_seen;
        int          n;
        rst = 1'b1;
        start = 1'b0;
        load_valid = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        rng_state = 32'd86;
        foreach (model_regs[i]) begin
            model_regs[i] = 32'd0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!active && load_ready)
            else stop_on_error("active high or load_ready low after reset");

        xor_program();
        execute_and_check("xor program", v0_seen, cycles_seen);
        assert (v0_seen === 32'h0000_0FF0)
            else stop_on_error($sformatf("xor program: v0 is %h, expected 00000ff0", v0_seen));

        repeat (20) begin
            r = next_random();
            alu_program(r[15:0], r[31:16]);
            execute_and_check("alu program", v0_seen, cycles_seen);
        end

        // the data word for the later load arrives while the loop runs
        r = next_random();
        preload = next_random();
        loop_program({12'd0, r[3:0]} + 16'd4, {14'd0, r[5:4]} + 16'd1);
        fork
            execute_and_check("loop program", v0_seen, cycles_seen);
            offer_during_fetch(preload_addr, preload);
        join

        r = next_random();
        store_load_program(r);
        execute_and_check("store and load program", v0_seen, cycles_seen);
        assert (v0_seen === r)
            else stop_on_error($sformatf("lw returned %h, sw stored %h", v0_seen, r));

        preload_read_program(preload_addr[15:0]);
        execute_and_check("preload read program", v0_seen, cycles_seen);
        assert (v0_seen === preload)
            else stop_on_error($sformatf("lw returned %h, load port wrote %h", v0_seen, preload));

        r = next_random();
        n = 4 + int'(r[3:0]);
        straight_program(n);
        execute_and_check("straight program", v0_seen, cycles_seen);
        assert (cycles_seen == 3 * (n + 1))
            else stop_on_error($sformatf("%0d ALU instructions took %0d cycles", n, cycles_seen));

        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+testbench
common/mips_pkg.sv
cpu/cpu_alu.sv
cpu/cpu_decoder.sv
cpu/cpu_regfile.sv
cpu/cpu_control.sv
hdl/avalon_ram.sv
hdl/mips_system.sv
testbench/mips_system_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        ?= mips_system_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
